// ==== source/csr_pkg.sv ====
// CSR unit shared types
package csr_pkg;

    parameter int XLEN = 32;

    // RV32I with MXL set to 1
    parameter logic [XLEN-1:0] ISA_CODE = 32'h4000_0100;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_cmd_e;

    typedef enum logic [11:0] {
        MSTATUS  = 12'h300,
        MISA     = 12'h301,
        MIE      = 12'h304,
        MTVEC    = 12'h305,
        MSCRATCH = 12'h340,
        MEPC     = 12'h341,
        MCAUSE   = 12'h342,
        MTVAL    = 12'h343,
        MIP      = 12'h344,
        MHARTID  = 12'hF14
    } csr_addr_e;

    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,
        LD_BU   = 3'd2,
        LD_H    = 3'd3,
        LD_HU   = 3'd4,
        LD_W    = 3'd5
    } ld_type_e;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_B    = 2'd1,
        ST_H    = 2'd2,
        ST_W    = 2'd3
    } st_type_e;

    typedef struct packed {
        logic ext;
        logic sw;
        logic tmr;
    } irq_vec_t;

    // One flag per trap source in priority order
    typedef struct packed {
        logic irq_ext;
        logic irq_sw;
        logic irq_tmr;
        logic ebreak;
        logic illegal;
        logic fetch_misalign;
        logic ecall;
        logic store_misalign;
        logic load_misalign;
    } trap_req_t;

    // --------------------------------------------------
    // mcause codes
    // --------------------------------------------------
    parameter logic [XLEN-1:0] CAUSE_IRQ_EXT        = 32'h8000_000B;
    parameter logic [XLEN-1:0] CAUSE_IRQ_SW         = 32'h8000_0003;
    parameter logic [XLEN-1:0] CAUSE_IRQ_TMR        = 32'h8000_0007;
    parameter logic [XLEN-1:0] CAUSE_BREAKPOINT     = 32'd3;
    parameter logic [XLEN-1:0] CAUSE_ILLEGAL        = 32'd2;
    parameter logic [XLEN-1:0] CAUSE_FETCH_MISALIGN = 32'd0;
    parameter logic [XLEN-1:0] CAUSE_ECALL_M        = 32'd11;
    parameter logic [XLEN-1:0] CAUSE_STORE_MISALIGN = 32'd6;
    parameter logic [XLEN-1:0] CAUSE_LOAD_MISALIGN  = 32'd4;

    parameter int MSTATUS_MIE_BIT  = 3;
    parameter int MSTATUS_MPIE_BIT = 7;
    parameter int MIE_EXT_BIT      = 11;
    parameter int MIE_SW_BIT       = 3;
    parameter int MIE_TMR_BIT      = 7;

endpackage

// ==== source/trap_if.sv ====
// Selected trap bus
`timescale 1ns/10ps

interface trap_if;
    import csr_pkg::*;

    logic            take;   // Trap taken this cycle
    logic            mret;   // Only when no trap
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] epc;
    logic [XLEN-1:0] tval;

    // Arbiter side
    modport arbiter (
        output take,
        output mret,
        output cause,
        output epc,
        output tval
    );

    // Register file side
    modport commit (
        input take,
        input mret,
        input cause,
        input epc,
        input tval
    );

endinterface

// ==== source/trap_detect.sv ====
// Trap source detection
`timescale 1ns/10ps

module trap_detect (
    input  csr_pkg::ld_type_e          ld_type,
    input  csr_pkg::st_type_e          st_type,
    input  logic [csr_pkg::XLEN-1:0]   ex_mem_addr,
    input  logic                       branch_taken,
    input  logic [csr_pkg::XLEN-1:0]   branch_target,
    input  logic                       illegal_instr,
    input  logic                       ecall,
    input  logic                       ebreak,
    input  csr_pkg::irq_vec_t          irq,
    input  logic                       mstatus_mie,
    input  csr_pkg::irq_vec_t          mie_en,
    output csr_pkg::trap_req_t         req,
    output logic                       wfi_wake
);
    import csr_pkg::*;

    logic ld_misalign;
    logic st_misalign;

    // --------------------------------------------------
    // Memory stage misalignment
    // --------------------------------------------------
    always_comb begin
        case (ld_type)
            LD_W:        ld_misalign = |ex_mem_addr[1:0];
            LD_H, LD_HU: ld_misalign = ex_mem_addr[0];
            default:     ld_misalign = 1'b0;   // Byte loads never fault
        endcase
    end

    always_comb begin
        case (st_type)
            ST_W:    st_misalign = |ex_mem_addr[1:0];
            ST_H:    st_misalign = ex_mem_addr[0];
            default: st_misalign = 1'b0;
        endcase
    end

    // Interrupts need both the local and the global enable
    assign req.irq_ext        = irq.ext & mie_en.ext & mstatus_mie;
    assign req.irq_sw         = irq.sw  & mie_en.sw  & mstatus_mie;
    assign req.irq_tmr        = irq.tmr & mie_en.tmr & mstatus_mie;
    assign req.ebreak         = ebreak;
    assign req.illegal        = illegal_instr;
    assign req.fetch_misalign = branch_taken & branch_target[0];
    assign req.ecall          = ecall;
    assign req.store_misalign = st_misalign;
    assign req.load_misalign  = ld_misalign;

    // WFI wakes even with MIE clear
    assign wfi_wake = (irq.ext & mie_en.ext) |
                      (irq.sw  & mie_en.sw)  |
                      (irq.tmr & mie_en.tmr);

endmodule

// ==== source/trap_arbiter.sv ====
// Trap priority arbiter
`timescale 1ns/10ps

module trap_arbiter (
    input  csr_pkg::trap_req_t         req,
    input  logic                       mret,
    input  logic [csr_pkg::XLEN-1:0]   ex_mem_addr,
    input  logic [csr_pkg::XLEN-1:0]   ex_mem_pc,
    input  logic [csr_pkg::XLEN-1:0]   id_pc,
    input  logic [csr_pkg::XLEN-1:0]   branch_target,
    input  logic [csr_pkg::XLEN-1:0]   id_instr,
    trap_if.arbiter                    trap,
    output logic                       mem_flush
);
    import csr_pkg::*;

    logic [XLEN-1:0] sel_cause;
    logic [XLEN-1:0] sel_tval;
    logic            lsu_fault;   // Winner came from the memory stage
    logic            any_req;

    // --------------------------------------------------
    // Fixed priority select
    // --------------------------------------------------
    always_comb begin
        sel_cause = '0;
        sel_tval  = '0;
        lsu_fault = 1'b0;
        if (req.irq_ext) begin
            sel_cause = CAUSE_IRQ_EXT;
        end else if (req.irq_sw) begin
            sel_cause = CAUSE_IRQ_SW;
        end else if (req.irq_tmr) begin
            sel_cause = CAUSE_IRQ_TMR;
        end else if (req.ebreak) begin
            sel_cause = CAUSE_BREAKPOINT;
        end else if (req.illegal) begin
            sel_cause = CAUSE_ILLEGAL;
            sel_tval  = id_instr;        // Faulting instruction word
        end else if (req.fetch_misalign) begin
            sel_cause = CAUSE_FETCH_MISALIGN;
            sel_tval  = branch_target;
        end else if (req.ecall) begin
            sel_cause = CAUSE_ECALL_M;
        end else if (req.store_misalign) begin
            sel_cause = CAUSE_STORE_MISALIGN;
            sel_tval  = ex_mem_addr;
            lsu_fault = 1'b1;
        end else if (req.load_misalign) begin
            sel_cause = CAUSE_LOAD_MISALIGN;
            sel_tval  = ex_mem_addr;
            lsu_fault = 1'b1;
        end
    end

    assign any_req = |req;

    assign trap.take  = any_req;
    assign trap.mret  = mret & ~any_req;   // Trap wins
    assign trap.cause = sel_cause;
    assign trap.epc   = lsu_fault ? ex_mem_pc : id_pc;
    assign trap.tval  = sel_tval;

    // Kill the access still sitting in EX/MEM
    assign mem_flush = any_req & lsu_fault;

endmodule

// ==== source/csr_file.sv ====
// Machine-mode CSR register file
`timescale 1ns/10ps

module csr_file #(
    parameter int unsigned HART_ID = 0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    trap_if.commit                     trap,
    input  csr_pkg::csr_cmd_e          csr_cmd,
    input  logic [11:0]                csr_addr,
    input  logic                       csr_use_zimm,
    input  logic [4:0]                 csr_zimm,
    input  logic [csr_pkg::XLEN-1:0]   rs1_data,
    input  csr_pkg::irq_vec_t          irq,
    output logic [csr_pkg::XLEN-1:0]   csr_rd_data,
    output logic                       redirect,
    output logic [csr_pkg::XLEN-1:0]   redirect_pc,
    output logic                       mstatus_mie,
    output csr_pkg::irq_vec_t          mie_en
);
    import csr_pkg::*;

    // Architectural state
    logic            mstatus_mie_q;
    logic            mstatus_mpie_q;
    irq_vec_t        mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtval_q;
    logic [XLEN-1:0] mscratch_q;

    logic [XLEN-1:0] mstatus_rd;
    logic [XLEN-1:0] mie_rd;
    logic [XLEN-1:0] mip_rd;
    logic [XLEN-1:0] csr_cur;     // Current value at csr_addr
    logic [XLEN-1:0] operand;
    logic [XLEN-1:0] wr_data;
    logic            wr_en;

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    always_comb begin
        mstatus_rd                   = '0;
        mstatus_rd[MSTATUS_MIE_BIT]  = mstatus_mie_q;
        mstatus_rd[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
        mie_rd                       = '0;
        mie_rd[MIE_EXT_BIT]          = mie_q.ext;
        mie_rd[MIE_SW_BIT]           = mie_q.sw;
        mie_rd[MIE_TMR_BIT]          = mie_q.tmr;
        mip_rd                       = '0;   // Live pending inputs
        mip_rd[MIE_EXT_BIT]          = irq.ext;
        mip_rd[MIE_SW_BIT]           = irq.sw;
        mip_rd[MIE_TMR_BIT]          = irq.tmr;
    end

    always_comb begin
        case (csr_addr)
            MSTATUS:  csr_cur = mstatus_rd;
            MISA:     csr_cur = ISA_CODE;
            MIE:      csr_cur = mie_rd;
            MTVEC:    csr_cur = mtvec_q;
            MSCRATCH: csr_cur = mscratch_q;
            MEPC:     csr_cur = mepc_q;
            MCAUSE:   csr_cur = mcause_q;
            MTVAL:    csr_cur = mtval_q;
            MIP:      csr_cur = mip_rd;
            MHARTID:  csr_cur = XLEN'(HART_ID);
            default:  csr_cur = '0;
        endcase
    end

    assign csr_rd_data = (csr_cmd != CSR_NONE) ? csr_cur : '0;

    // --------------------------------------------------
    // Write data
    // --------------------------------------------------
    assign operand = csr_use_zimm ? {{(XLEN-5){1'b0}}, csr_zimm} : rs1_data;

    always_comb begin
        case (csr_cmd)
            CSR_WRITE: wr_data = operand;
            CSR_SET:   wr_data = csr_cur | operand;
            CSR_CLEAR: wr_data = csr_cur & ~operand;
            default:   wr_data = csr_cur;
        endcase
    end

    // Set and clear with a zero operand are read only
    assign wr_en = (csr_cmd == CSR_WRITE) |
                   (((csr_cmd == CSR_SET) | (csr_cmd == CSR_CLEAR)) & (|operand));

    // --------------------------------------------------
    // A trap beats a CSR write to the trap record
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else if (trap.take) begin
            mepc_q   <= trap.epc;
            mcause_q <= trap.cause;
            mtval_q  <= trap.tval;
        end else if (wr_en) begin
            if (csr_addr == MEPC)
                mepc_q <= wr_data;
            if (csr_addr == MCAUSE)
                mcause_q <= wr_data;
            if (csr_addr == MTVAL)
                mtval_q <= wr_data;
        end
    end

    // MIE/MPIE stack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
        end else if (trap.take) begin
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
        end else if (trap.mret) begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end else if (wr_en && csr_addr == MSTATUS) begin
            mstatus_mie_q  <= wr_data[MSTATUS_MIE_BIT];
            mstatus_mpie_q <= wr_data[MSTATUS_MPIE_BIT];
        end
    end

    // Software-only registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end else if (wr_en) begin
            if (csr_addr == MIE) begin
                mie_q.ext <= wr_data[MIE_EXT_BIT];
                mie_q.sw  <= wr_data[MIE_SW_BIT];
                mie_q.tmr <= wr_data[MIE_TMR_BIT];
            end
            if (csr_addr == MTVEC)
                mtvec_q <= {wr_data[XLEN-1:2], 2'b00};   // Direct mode only
            if (csr_addr == MSCRATCH)
                mscratch_q <= wr_data;
        end
    end

    // --------------------------------------------------
    // Redirect and status to detect stage
    // --------------------------------------------------
    assign redirect    = trap.take | trap.mret;
    assign redirect_pc = trap.take ? {mtvec_q[XLEN-1:2], 2'b00} : mepc_q;

    assign mstatus_mie = mstatus_mie_q;
    assign mie_en      = mie_q;

endmodule

// ==== source/csr_unit.sv ====
// CSR unit top level
`timescale 1ns/10ps

module csr_unit #(
    parameter int unsigned HART_ID = 0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       irq_ext,
    input  logic                       irq_sw,
    input  logic                       irq_tmr,
    input  logic [csr_pkg::XLEN-1:0]   ex_mem_addr,
    input  csr_pkg::ld_type_e          ex_mem_ld_type,
    input  csr_pkg::st_type_e          ex_mem_st_type,
    input  logic [csr_pkg::XLEN-1:0]   ex_mem_pc,
    input  logic                       branch_taken,
    input  logic [csr_pkg::XLEN-1:0]   branch_target,
    input  logic [csr_pkg::XLEN-1:0]   id_pc,
    input  logic [csr_pkg::XLEN-1:0]   id_instr,
    input  logic                       illegal_instr,
    input  logic                       ecall,
    input  logic                       ebreak,
    input  logic                       mret,
    input  csr_pkg::csr_cmd_e          csr_cmd,
    input  logic [11:0]                csr_addr,
    input  logic                       csr_use_zimm,
    input  logic [4:0]                 csr_zimm,
    input  logic [csr_pkg::XLEN-1:0]   rs1_data,
    output logic [csr_pkg::XLEN-1:0]   csr_rd_data,
    output logic                       redirect,
    output logic [csr_pkg::XLEN-1:0]   redirect_pc,
    output logic                       mem_flush,
    output logic                       wfi_wake
);
    import csr_pkg::*;

    irq_vec_t  irq;
    trap_req_t req;          // Detect to arbitrate
    logic      mstatus_mie;  // Fed back from the register file
    irq_vec_t  mie_en;

    assign irq.ext = irq_ext;
    assign irq.sw  = irq_sw;
    assign irq.tmr = irq_tmr;

    trap_if trap_bus ();

    // --------------------------------------------------
    // Detect, arbitrate, commit
    // --------------------------------------------------
    trap_detect u_trap_detect (
        .ld_type       (ex_mem_ld_type),
        .st_type       (ex_mem_st_type),
        .ex_mem_addr   (ex_mem_addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .illegal_instr (illegal_instr),
        .ecall         (ecall),
        .ebreak        (ebreak),
        .irq           (irq),
        .mstatus_mie   (mstatus_mie),
        .mie_en        (mie_en),
        .req           (req),
        .wfi_wake      (wfi_wake)
    );

    trap_arbiter u_trap_arbiter (
        .req           (req),
        .mret          (mret),
        .ex_mem_addr   (ex_mem_addr),
        .ex_mem_pc     (ex_mem_pc),
        .id_pc         (id_pc),
        .branch_target (branch_target),
        .id_instr      (id_instr),
        .trap          (trap_bus.arbiter),
        .mem_flush     (mem_flush)
    );

    csr_file #(
        .HART_ID (HART_ID)
    ) u_csr_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .trap         (trap_bus.commit),
        .csr_cmd      (csr_cmd),
        .csr_addr     (csr_addr),
        .csr_use_zimm (csr_use_zimm),
        .csr_zimm     (csr_zimm),
        .rs1_data     (rs1_data),
        .irq          (irq),
        .csr_rd_data  (csr_rd_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .mstatus_mie  (mstatus_mie),
        .mie_en       (mie_en)
    );

endmodule

// ==== include/csr_tb_vectors.svh ====
// CSR unit test vectors
`ifndef CSR_TB_VECTORS_SVH
`define CSR_TB_VECTORS_SVH

// Each row holds cmd, addr, operand source, operand, {ext,sw,tmr,illegal,ecall,ebreak,mret},
// memory access, address, rd data, {redirect,flush,wake} and redirect pc

// --------------------------------------------------
// CSR commands on mscratch (rd data from the model)
// --------------------------------------------------
add_row(CSR_NONE, MISA, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_WRITE, MSCRATCH, RND, 'h0, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_SET, MSCRATCH, RND, 'h0, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_CLEAR, MSCRATCH, RND, 'h0, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_SET, MSCRATCH, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_CLEAR, MSCRATCH, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_WRITE, MSCRATCH, ZIMM, 'h15, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_SET, MSCRATCH, ZIMM, 'h0a, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_CLEAR, MSCRATCH, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);

// --------------------------------------------------
// Masked and constant CSRs
// --------------------------------------------------
add_row(CSR_WRITE, MIE, RS1, '1, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_WRITE, MSTATUS, RS1, '1, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_CLEAR, MIE, RS1, 'h8, 7'h00, NO_MEM, 'h0, 'h888, 3'b000, 'h0);
add_row(CSR_CLEAR, MSTATUS, RS1, '1, 7'h00, NO_MEM, 'h0, 'h88, 3'b000, 'h0);
add_row(CSR_SET, MIE, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h880, 3'b000, 'h0);
add_row(CSR_SET, MSTATUS, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_WRITE, MTVEC, RS1, 'h103, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_SET, MTVEC, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h100, 3'b000, 'h0);
add_row(CSR_WRITE, MISA, RS1, '1, 7'h00, NO_MEM, 'h0, 'h40000100, 3'b000, 'h0);
add_row(CSR_SET, MISA, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h40000100, 3'b000, 'h0);
add_row(CSR_WRITE, MHARTID, RS1, '1, 7'h00, NO_MEM, 'h0, HART, 3'b000, 'h0);
add_row(CSR_SET, MHARTID, RS1, 'h0, 7'h00, NO_MEM, 'h0, HART, 3'b000, 'h0);

// --------------------------------------------------
// Exceptions and priority
// --------------------------------------------------
add_row(CSR_NONE, MISA, RS1, 'h0, 7'h08, NO_MEM, 'h0, 'h0, 3'b100, 'h100);   // Illegal
add_row(CSR_SET, MCAUSE, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h2, 3'b000, 'h0);
add_row(CSR_SET, MEPC, RS1, 'h0, 7'h00, NO_MEM, 'h0, ID_PC, 3'b000, 'h0);
add_row(CSR_SET, MTVAL, RS1, 'h0, 7'h00, NO_MEM, 'h0, INSTR, 3'b000, 'h0);
add_row(CSR_NONE, MISA, RS1, 'h0, 7'h04, NO_MEM, 'h0, 'h0, 3'b100, 'h100);   // Ecall
add_row(CSR_SET, MCAUSE, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'hb, 3'b000, 'h0);
add_row(CSR_SET, MEPC, RS1, 'h0, 7'h00, NO_MEM, 'h0, ID_PC, 3'b000, 'h0);
add_row(CSR_SET, MTVAL, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h0, 3'b000, 'h0);
add_row(CSR_NONE, MISA, RS1, 'h0, 7'h00, LD_WORD, 'h2002, 'h0, 3'b110, 'h100);
add_row(CSR_SET, MCAUSE, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h4, 3'b000, 'h0);
add_row(CSR_SET, MEPC, RS1, 'h0, 7'h00, NO_MEM, 'h0, EX_PC, 3'b000, 'h0);
add_row(CSR_SET, MTVAL, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h2002, 3'b000, 'h0);
add_row(CSR_NONE, MISA, RS1, 'h0, 7'h0b, ST_WORD, 'h2001, 'h0, 3'b100, 'h100);
add_row(CSR_SET, MCAUSE, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h3, 3'b000, 'h0);

// --------------------------------------------------
// Timer interrupt, then mret
// --------------------------------------------------
add_row(CSR_SET, MIP, RS1, 'h0, 7'h10, NO_MEM, 'h0, 'h80, 3'b001, 'h0);
add_row(CSR_SET, MSTATUS, RS1, 'h8, 7'h10, NO_MEM, 'h0, 'h0, 3'b001, 'h0);
add_row(CSR_NONE, MISA, RS1, 'h0, 7'h10, NO_MEM, 'h0, 'h0, 3'b101, 'h100);
add_row(CSR_SET, MCAUSE, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h80000007, 3'b000, 'h0);
add_row(CSR_SET, MSTATUS, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h80, 3'b000, 'h0);
add_row(CSR_WRITE, MEPC, RS1, 'ha00, 7'h00, NO_MEM, 'h0, ID_PC, 3'b000, 'h0);
add_row(CSR_NONE, MISA, RS1, 'h0, 7'h01, NO_MEM, 'h0, 'h0, 3'b100, 'ha00);   // mret
add_row(CSR_SET, MSTATUS, RS1, 'h0, 7'h00, NO_MEM, 'h0, 'h88, 3'b000, 'h0);

`endif

// ==== verification/csr_unit_tb.sv ====
// CSR unit testbench
`timescale 1ns/10ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam int          CLK_PERIOD = 20;
    localparam int          HART       = 5;
    localparam logic [31:0] ID_PC      = 32'h0000_0480;
    localparam logic [31:0] EX_PC      = 32'h0000_047c;
    localparam logic [31:0] INSTR      = 32'h0000_707f;
    localparam logic [31:0] BR_TGT     = 32'h0000_0600;

    typedef enum logic [1:0] {RS1, ZIMM, RND} src_e;
    typedef enum logic [1:0] {NO_MEM, LD_WORD, ST_WORD} mem_e;

    typedef struct packed {
        csr_cmd_e    cmd;
        logic [11:0] addr;
        src_e        src;
        logic [31:0] opnd;
        logic [6:0]  ctl;         // {ext, sw, tmr, illegal, ecall, ebreak, mret}
        mem_e        mem;
        logic [31:0] maddr;
        logic [31:0] exp_rd;
        logic [2:0]  exp_flags;   // {redirect, mem_flush, wfi_wake}
        logic [31:0] exp_rpc;
    } row_t;

    logic clk, rst_n;
    logic irq_ext, irq_sw, irq_tmr;
    logic [31:0] ex_mem_addr, ex_mem_pc, branch_target, id_pc, id_instr, rs1_data;
    ld_type_e ex_mem_ld_type;
    st_type_e ex_mem_st_type;
    logic branch_taken, illegal_instr, ecall, ebreak, mret;
    csr_cmd_e csr_cmd;
    logic [11:0] csr_addr;
    logic csr_use_zimm;
    logic [4:0] csr_zimm;
    logic [31:0] csr_rd_data, redirect_pc;
    logic redirect, mem_flush, wfi_wake;

    row_t        rows[$];
    int          cur_row;
    int          checks;
    int          errors;
    bit          table_ready;
    logic [31:0] lfsr_state = 32'h7fc5a113;
    logic [31:0] scratch    = '0;   // Expected mscratch contents

    csr_unit #(.HART_ID(HART)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            w[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [31:0] scratch_after(input csr_cmd_e cmd,
                                                  input logic [31:0] old,
                                                  input logic [31:0] opnd);
        case (cmd)
            CSR_WRITE: return opnd;
            CSR_SET:   return old | opnd;
            CSR_CLEAR: return old & ~opnd;
            default:   return old;
        endcase
    endfunction

    task automatic add_row(input csr_cmd_e cmd, input logic [11:0] addr, input src_e src,
                           input logic [31:0] opnd, input logic [6:0] ctl, input mem_e mem,
                           input logic [31:0] maddr, input logic [31:0] exp_rd,
                           input logic [2:0] exp_flags, input logic [31:0] exp_rpc);
        rows.push_back({cmd, addr, src, opnd, ctl, mem, maddr, exp_rd, exp_flags, exp_rpc});
    endtask

    task automatic build_table;
        `include "csr_tb_vectors.svh"
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d %s = %h, expected %h",
                     $time, cur_row, what, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Table loop
    // --------------------------------------------------
    initial begin
        row_t        r;
        logic [31:0] rnd;
        logic [31:0] operand;    // What the DUT should use
        logic [31:0] exp_rd;
        rst_n = 1'b0;
        {irq_ext, irq_sw, irq_tmr, illegal_instr, ecall, ebreak, mret} = '0;
        ex_mem_addr    = '0;
        ex_mem_pc      = EX_PC;
        ex_mem_ld_type = LD_NONE;
        ex_mem_st_type = ST_NONE;
        branch_taken   = 1'b0;
        branch_target  = BR_TGT;
        id_pc          = ID_PC;
        id_instr       = INSTR;
        csr_cmd        = CSR_NONE;
        csr_addr       = '0;
        csr_use_zimm   = 1'b0;
        csr_zimm       = '0;
        rs1_data       = '0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (cur_row = 0; cur_row < rows.size(); cur_row++) begin
            r   = rows[cur_row];
            rnd = '0;
            if (r.src == RND)
                draw_word(rnd);
            operand = (r.src == ZIMM) ? {27'd0, r.opnd[4:0]} : (r.src == RND) ? rnd : r.opnd;
            @(posedge clk);
            csr_cmd        <= r.cmd;
            csr_addr       <= r.addr;
            csr_use_zimm   <= (r.src == ZIMM);
            csr_zimm       <= r.opnd[4:0];
            rs1_data       <= (r.src == ZIMM) ? ~r.opnd : operand;   // Decoy on zimm rows
            {irq_ext, irq_sw, irq_tmr, illegal_instr, ecall, ebreak, mret} <= r.ctl;
            ex_mem_ld_type <= (r.mem == LD_WORD) ? LD_W : LD_NONE;
            ex_mem_st_type <= (r.mem == ST_WORD) ? ST_W : ST_NONE;
            ex_mem_addr    <= r.maddr;
            @(negedge clk);
            exp_rd = (r.addr == MSCRATCH && r.cmd != CSR_NONE) ? scratch : r.exp_rd;
            check_value("csr_rd_data", csr_rd_data, exp_rd);
            check_value("redirect", redirect, r.exp_flags[2]);
            check_value("mem_flush", mem_flush, r.exp_flags[1]);
            check_value("wfi_wake", wfi_wake, r.exp_flags[0]);
            if (r.exp_flags[2])
                check_value("redirect_pc", redirect_pc, r.exp_rpc);
            if (r.addr == MSCRATCH)
                scratch = scratch_after(r.cmd, scratch, operand);
        end
        @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        #((rows.size() + 20) * CLK_PERIOD);
        $display("Watchdog expired before the table loop finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
source/csr_pkg.sv
source/trap_if.sv
source/trap_detect.sv
source/trap_arbiter.sv
source/csr_file.sv
source/csr_unit.sv
verification/csr_unit_tb.sv
